/* list.f */
+incdir+source
source/uartPkg.sv
source/baudTickGen.sv
source/uartFifo.sv
source/uartTrans.sv
source/uartRecv.sv
source/uartCtrl.sv
source/uartTop.sv
verification/uartTb.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module uartTb -f list.f -o uartSim \
	|| { echo "build error"; exit 1; }
./obj_dir/uartSim > sim.log 2>&1 ; cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log && exit 0 || exit 1

/* source/baudTickGen.sv */
`timescale 1ns/1ps
`include "uart_macros.svh"

// free running divider, one sTick every clksPerTick clocks
module baudTickGen
(
	input  logic clk,
	input  logic reset,
	output logic sTick
);

	logic [$clog2(`clksPerTick)-1:0] cntReg;	// clocks since last tick

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			cntReg <= '0;
		else if (sTick)
			cntReg <= '0;	// wrap
		else
			cntReg <= cntReg + 1'b1;
	end

	assign sTick = (cntReg == $bits(cntReg)'(`clksPerTick - 1));	// one cycle at wrap

	// both serial blocks count sTick as an event, never a level
	aTickPulse: assert property (@(posedge clk) disable iff (reset)
		sTick |=> !sTick);

endmodule

/* source/uartCtrl.sv */
`timescale 1ns/1ps

// processor side of the uart, decodes UARTrd, UARTwr and UARTstat
module uartCtrl import uartPkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    opStrobe,
	input  uartOp   op,
	input  logic    rxDoneTick,
	input  logic    txFull,
	input  logic    rxFull,
	input  logic    rxEmpty,
	input  uartData rxHead,
	output logic    txPush,
	output logic    rxPop,
	output logic    rxPush,
	output uartData rdData
);

	logic    overrun;	// sticky, a received byte was lost
	logic    isRead, isStat;
	uartData statusByte;

	assign isRead = opStrobe && (op == opRead);
	assign isStat = opStrobe && (op == opStat);
	assign txPush = opStrobe && (op == opWrite) && !txFull;	// full fifo drops the write
	assign rxPop  = isRead;			// empty pop ignored in the fifo
	assign rxPush = rxDoneTick && !rxFull;

	// status byte as seen by the processor
	assign statusByte = {4'b0000, overrun, rxFull, txFull, rxEmpty};

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			overrun <= 1'b0;
		else if (rxDoneTick && rxFull)
			overrun <= 1'b1;	// a new loss beats a clear in the same cycle
		else if (isStat)
			overrun <= 1'b0;	// read clears
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			rdData <= '0;
		else if (isRead && !rxEmpty)
			rdData <= rxHead;	// head before the pop
		else if (isStat)
			rdData <= statusByte;
	end

	aNoPushFull: assert property (@(posedge clk) disable iff (reset)
		rxPush |-> !rxFull);

endmodule

/* source/uartFifo.sv */
`timescale 1ns/1ps
`include "uart_macros.svh"

module uartFifo import uartPkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    push,
	input  logic    pop,
	input  uartData din,
	output uartData dout,
	output logic    full,
	output logic    empty
);

	uartData                 mem [`fifoDepth];
	logic [`fifoAddrLen-1:0] wrPtr, rdPtr;
	fifoCount                count;	// occupancy
	logic                    doPush, doPop;

	// overflow and underflow are dropped here
	assign doPush = push && !full;
	assign doPop  = pop && !empty;

	////////////////////////////////////////////////////////////////////////////
	// storage

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= din;
	end

	assign dout = mem[rdPtr];	// head, valid while !empty

	////////////////////////////////////////////////////////////////////////////
	// pointers and fill level

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;	// wraps at fifoDepth
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// none, or both at once
			endcase
		end
	end

	assign full  = (count == fifoCount'(`fifoDepth));
	assign empty = (count == '0);

	aFullEmpty: assert property (@(posedge clk) disable iff (reset)
		!(full && empty));
	aCountMax: assert property (@(posedge clk) disable iff (reset)
		count <= fifoCount'(`fifoDepth));

endmodule

/* source/uartPkg.sv */
`include "uart_macros.svh"

package uartPkg;

	// one byte on the processor data bus
	typedef logic [`dataBits-1:0] uartData;

	// fifo fill level, 0 up to fifoDepth inclusive
	typedef logic [`fifoAddrLen:0] fifoCount;

	// uart operations as decoded from the instruction
	typedef enum logic [1:0]
	{
		opNone,
		opRead,		// UARTrd
		opWrite,	// UARTwr
		opStat		// UARTstat
	} uartOp;

	// serializer states
	typedef enum logic [1:0] {tIdle, tStart, tData, tStop} txState;

	// deserializer states
	typedef enum logic [1:0] {rIdle, rStart, rData, rStop} rxState;

endpackage

/* source/uartRecv.sv */
`timescale 1ns/1ps
`include "uart_macros.svh"

// oversampling deserializer, samples in the middle of each bit
module uartRecv import uartPkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    sTick,
	input  logic    rx,
	output logic    rxDoneTick,	// one cycle, mid stop bit
	output uartData rxByte
);

	rxState                          stateReg, stateNext;
	logic [$clog2(`ticksPerBit)-1:0] sReg, sNext;	// ticks within bit
	logic [$clog2(`dataBits)-1:0]    nReg, nNext;	// data bits taken
	uartData                         bReg, bNext;	// shifts in from the top
	logic                            rxMeta, rxSync, rxPrev;

	// rx is asynchronous to clk
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxPrev <= 1'b1;
		end
		else
		begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			rxPrev <= rxSync;	// for edge detect
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= rIdle;
			sReg     <= '0;
			nReg     <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	always_comb
	begin
		stateNext  = stateReg;
		sNext      = sReg;
		nNext      = nReg;
		bNext      = bReg;
		rxDoneTick = 1'b0;
		case (stateReg)
			rIdle:
				if (rxPrev && !rxSync)	// falling edge, start bit begins
				begin
					sNext     = '0;
					stateNext = rStart;
				end
			rStart:
				if (sTick)
				begin
					if (sReg == $bits(sReg)'(`ticksPerBit / 2 - 1))	// tick 7, mid start bit
					begin
						sNext     = '0;
						nNext     = '0;
						stateNext = rxSync ? rIdle : rData;	// glitch goes back to idle
					end
					else
						sNext = sReg + 1'b1;
				end
			rData:
				if (sTick)
				begin
					if (sReg == $bits(sReg)'(`ticksPerBit - 1))
					begin
						sNext = '0;
						bNext = {rxSync, bReg[`dataBits-1:1]};	// LSB first
						if (nReg == $bits(nReg)'(`dataBits - 1))
							stateNext = rStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			rStop:
				if (sTick)
				begin
					if (sReg == $bits(sReg)'(`sbTick - 1))
					begin
						rxDoneTick = 1'b1;	// byte complete
						stateNext  = rIdle;
					end
					else
						sNext = sReg + 1'b1;
				end
			default: stateNext = rIdle;
		endcase
	end

	assign rxByte = bReg;

	aDonePulse: assert property (@(posedge clk) disable iff (reset)
		rxDoneTick |=> !rxDoneTick);

endmodule

/* source/uartTop.sv */
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// uart peripheral
// ctrl -> tx fifo -> serializer -> tx
// rx -> deserializer -> rx fifo -> ctrl
////////////////////////////////////////////////////////////////////////////

module uartTop import uartPkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    opStrobe,
	input  uartOp   op,
	input  uartData wrData,
	input  logic    rx,
	output uartData rdData,
	output logic    tx
);

	logic    sTick;
	logic    txPush, txFull, txEmpty, txStart, txDoneTick;
	logic    rxPush, rxPop, rxFull, rxEmpty, rxDoneTick;
	uartData txHead, rxHead, rxByte;

	assign txStart = !txEmpty;	// send while anything is queued

	uartCtrl ctrl_i
	(
		.clk        (clk),
		.reset      (reset),
		.opStrobe   (opStrobe),
		.op         (op),
		.rxDoneTick (rxDoneTick),
		.txFull     (txFull),
		.rxFull     (rxFull),
		.rxEmpty    (rxEmpty),
		.rxHead     (rxHead),
		.txPush     (txPush),
		.rxPop      (rxPop),
		.rxPush     (rxPush),
		.rdData     (rdData)
	);

	baudTickGen baud_i (.clk(clk), .reset(reset), .sTick(sTick));

	uartFifo txFifo
	(
		.clk   (clk),
		.reset (reset),
		.push  (txPush),
		.pop   (txDoneTick),	// serializer takes the head
		.din   (wrData),
		.dout  (txHead),
		.full  (txFull),
		.empty (txEmpty)
	);

	uartTrans trans_i
	(
		.clk        (clk),
		.reset      (reset),
		.sTick      (sTick),
		.txStart    (txStart),
		.din        (txHead),
		.txDoneTick (txDoneTick),
		.tx         (tx)
	);

	uartRecv recv_i
	(
		.clk        (clk),
		.reset      (reset),
		.sTick      (sTick),
		.rx         (rx),
		.rxDoneTick (rxDoneTick),
		.rxByte     (rxByte)
	);

	uartFifo rxFifo
	(
		.clk   (clk),
		.reset (reset),
		.push  (rxPush),	// gated against full in ctrl
		.pop   (rxPop),
		.din   (rxByte),
		.dout  (rxHead),
		.full  (rxFull),
		.empty (rxEmpty)
	);

endmodule

/* source/uartTrans.sv */
`timescale 1ns/1ps
`include "uart_macros.svh"

// 4-state serializer: idle, start, data, stop
module uartTrans import uartPkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    sTick,
	input  logic    txStart,	// level, high while the tx fifo has data
	input  uartData din,		// tx fifo head
	output logic    txDoneTick,	// doubles as tx fifo pop
	output logic    tx
);

	txState                           stateReg, stateNext;
	logic [$clog2(`ticksPerBit)-1:0] sReg, sNext;	// tick counter
	logic [$clog2(`dataBits)-1:0]    nReg, nNext;	// bit counter
	uartData                         bReg, bNext;	// shift reg, LSB goes out first
	logic                            txReg, txNext;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= tIdle;
			sReg     <= '0;
			nReg     <= '0;
			txReg    <= 1'b1;	// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			txReg    <= txNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;	// payload

	////////////////////////////////////////////////////////////////////////////
	// next state

	always_comb
	begin
		stateNext  = stateReg;
		sNext      = sReg;
		nNext      = nReg;
		bNext      = bReg;
		txNext     = txReg;
		txDoneTick = 1'b0;
		case (stateReg)
			tIdle:
			begin
				txNext = 1'b1;
				if (txStart)
				begin
					txDoneTick = 1'b1;	// pop the fifo
					bNext      = din;	// grab head before pop moves it
					txNext     = 1'b0;	// start bit from next edge
					sNext      = '0;
					stateNext  = tStart;
				end
			end
			tStart:
			begin
				txNext = 1'b0;
				if (sTick)
				begin
					if (sReg == $bits(sReg)'(`ticksPerBit - 1))
					begin
						sNext     = '0;
						nNext     = '0;
						txNext    = bReg[0];	// first data bit
						stateNext = tData;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			tData:
			begin
				txNext = bReg[0];
				if (sTick)
				begin
					if (sReg == $bits(sReg)'(`ticksPerBit - 1))
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == $bits(nReg)'(`dataBits - 1))
						begin
							txNext    = 1'b1;	// stop bit
							stateNext = tStop;
						end
						else
						begin
							txNext = bReg[1];	// next bit out
							nNext  = nReg + 1'b1;
						end
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			tStop:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == $bits(sReg)'(`sbTick - 1))
						stateNext = tIdle;
					else
						sNext = sReg + 1'b1;
				end
			end
			default: stateNext = tIdle;
		endcase
	end

	assign tx = txReg;

	aDoneIdle: assert property (@(posedge clk) disable iff (reset)
		txDoneTick |-> stateReg == tIdle);
	aIdleHigh: assert property (@(posedge clk) disable iff (reset)
		stateReg == tIdle |-> tx);

endmodule

/* source/uart_macros.svh */
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// frame format

`define dataBits	8	// data bits per frame
`define sbTick		16	// ticks in the stop bit, 16 = one stop bit
`define ticksPerBit	16	// oversampling factor

////////////////////////////////////////////////////////////////////////////
// baud rate

// clocks per sample tick
// kept tiny so a frame is only 640 clocks
`define clksPerTick	4

////////////////////////////////////////////////////////////////////////////
// fifo sizing

`define fifoDepth	16
`define fifoAddrLen	4	// log2 of fifoDepth

`endif

/* verification/uartTb.sv */
`timescale 1ns/1ps
`include "uart_macros.svh"

module uartTb import uartPkg::*;
();

	// 18 frames of ~645 clocks is about 11600 cycles, doubled for margin
	localparam int maxCycles = 25000;

	logic    clk;
	logic    reset;
	logic    opStrobe;
	uartOp   op;
	uartData wrData;
	uartData rdData;
	logic    tx, rx;

	uartData sentQ[$];	// accepted by the tx fifo, frame not started yet
	uartData rxQ[$];	// expected contents of the rx fifo
	uartData rdModel;	// expected rdData
	logic    overrunFlag;
	int      rxFrames = 0;	// rxDoneTick pulses seen
	int      framesChecked = 0;	// frames decoded by the monitor
	int      cycles = 0;
	integer  seed;

	assign rx = tx;	// serial loopback

	uartTop dut_i
	(
		.clk      (clk),
		.reset    (reset),
		.opStrobe (opStrobe),
		.op       (op),
		.wrData   (wrData),
		.rx       (rx),
		.rdData   (rdData),
		.tx       (tx)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;	// 20 ns period

	////////////////////////////////////////////////////////////////////////////
	// reference model and checking

	function automatic uartData expectedStatus(int rxCount, int txCount, logic overrunModel);
		uartData s;
		s    = '0;
		s[0] = (rxCount == 0);	// rxEmpty
		s[1] = (txCount == `fifoDepth);	// txFull
		s[2] = (rxCount == `fifoDepth);	// rxFull
		s[3] = overrunModel;
		return s;
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic compare(input string name, input uartData got, input uartData exp);
		if (got !== exp)
			failRun($sformatf("MISMATCH at time %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	// one cycle of strobe, model updated at drive time
	task automatic doOp(input uartOp kind, input uartData data);
		opStrobe = 1'b1;
		op       = kind;
		wrData   = data;
		case (kind)
			opWrite:
				if (sentQ.size() < `fifoDepth)
					sentQ.push_back(data);	// else dropped
			opRead:
				if (rxQ.size() > 0)
					rdModel = rxQ.pop_front();	// old head
			opStat:
			begin
				rdModel     = expectedStatus(rxQ.size(), sentQ.size(), overrunFlag);
				overrunFlag = 1'b0;	// read clears
			end
			default: ;
		endcase
		@(posedge clk);
		#2;
	endtask

	task automatic endOps();
		opStrobe = 1'b0;
		op       = opNone;
	endtask

	task automatic syncDrive();
		@(posedge clk);
		#2;
	endtask

	// rx side done and monitor done, whichever is later
	task automatic waitFrames(input int n);
		while (rxFrames < n || framesChecked < n)
			@(posedge clk);
		syncDrive();
	endtask

	always @(posedge clk)
	begin
		if (dut_i.rxDoneTick)
			rxFrames++;
		cycles++;
		if (cycles >= maxCycles)
			failRun("timeout, the run hung before all tests finished");
	end

	////////////////////////////////////////////////////////////////////////////
	// serial monitor on tx

	initial
	begin
		uartData expByte;
		forever
		begin
			@(negedge tx);	// start bit begins, fifo pop in the same edge
			if (sentQ.size() == 0)
				failRun("a frame started on tx with no byte queued");
			expByte = sentQ.pop_front();
			repeat (32) @(negedge clk);	// mid start bit
			compare("tx start bit", tx, 0);
			for (int k = 0; k < `dataBits; k++)
			begin
				repeat (64) @(negedge clk);
				compare($sformatf("tx data bit %0d", k), tx, expByte[k]);	// LSB first
			end
			repeat (64) @(negedge clk);
			compare("tx stop bit", tx, 1);
			if (rxQ.size() < `fifoDepth)
				rxQ.push_back(expByte);
			else
				overrunFlag = 1'b1;	// byte lost at the rx fifo
			framesChecked++;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence

	initial
	begin
		reset       = 1'b1;
		opStrobe    = 1'b0;
		op          = opNone;
		wrData      = '0;
		rdModel     = '0;
		overrunFlag = 1'b0;
		seed        = 32'h2514;
		repeat (8) @(posedge clk);
		#2 reset = 1'b0;

		// idle after reset
		compare("tx", tx, 1);
		compare("rdData", rdData, 0);
		syncDrive();
		doOp(opStat, '0);
		endOps();
		compare("rdData status", rdData, rdModel);

		// single frame, then read back
		syncDrive();
		doOp(opWrite, uartData'($random(seed)));
		endOps();
		waitFrames(1);
		doOp(opRead, '0);
		endOps();
		compare("rdData read", rdData, rdModel);
		while (dut_i.trans_i.stateReg != tIdle)	// let the stop bit finish
			@(posedge clk);

		// 17 writes back to back, first one leaves at once
		syncDrive();
		for (int i = 0; i < 17; i++)
			doOp(opWrite, uartData'($random(seed)));
		doOp(opStat, '0);
		compare("rdData status", rdData, rdModel);
		compare("status txFull", rdData[1], 1);
		doOp(opWrite, uartData'($random(seed)));	// dropped, fifo full
		endOps();

		// 1 + 17 frames in total, the last one overflows
		waitFrames(18);
		doOp(opStat, '0);
		compare("rdData status", rdData, rdModel);
		compare("status overrun", rdData[3], 1);
		doOp(opStat, '0);
		endOps();
		compare("rdData status", rdData, rdModel);

		// drain the rx fifo in order
		syncDrive();
		for (int i = 0; i < `fifoDepth; i++)
		begin
			doOp(opRead, '0);
			compare("rdData read", rdData, rdModel);
		end
		doOp(opStat, '0);
		endOps();
		compare("rdData status", rdData, rdModel);

		// a frame from the dropped write would start within this bit time
		repeat (`ticksPerBit * `clksPerTick) @(posedge clk);
		#2;

		if (tx !== 1'b1 || sentQ.size() != 0 || rxQ.size() != 0)
			failRun("tx is not idle at the end, or bytes are left over in the model");
		else
		begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule
